// ==== common/loopback_pkg.sv ====
`default_nettype none

package loopback_pkg;

    // ******************************
    // widths and default sizes.
    // ******************************
    localparam int DATA_WIDTH_DEF = 64;
    localparam int PORT_WIDTH     = 2;  // loopback port number, fixed by the system.
    localparam int CORE_WIDTH_DEF = 4;
    localparam int SLOT_WIDTH_DEF = 3;
    localparam int TAG_MID_WIDTH  = 5;  // middle field, never part of the index.
    localparam int PORT_COUNT_DEF = 2;
    localparam int FIFO_DEPTH_DEF = 16; // power of two.

    // working width for tag and index arithmetic.
    localparam int TAG_CALC_WIDTH = 32;

    // map index = {core field, slot field}; caller keeps the low core+slot bits.
    function automatic logic [TAG_CALC_WIDTH-1:0] tag_to_index(
        input logic [TAG_CALC_WIDTH-1:0] tag,
        input int                        core_width,
        input int                        slot_width
    );
        logic [TAG_CALC_WIDTH-1:0] core_mask;
        logic [TAG_CALC_WIDTH-1:0] slot_mask;
        logic [TAG_CALC_WIDTH-1:0] core_f;
        core_mask = (TAG_CALC_WIDTH'(1) << core_width) - TAG_CALC_WIDTH'(1);
        slot_mask = (TAG_CALC_WIDTH'(1) << slot_width) - TAG_CALC_WIDTH'(1);
        core_f    = (tag >> TAG_MID_WIDTH) & core_mask; // core sits above the middle field.
        return (core_f << slot_width) | (tag & slot_mask);
    endfunction

endpackage

`default_nettype wire

// ==== logic/axis_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_fifo #(
    parameter int DATA_WIDTH = loopback_pkg::DATA_WIDTH_DEF,
    parameter int DEPTH      = loopback_pkg::FIFO_DEPTH_DEF,
    parameter int DEST_WIDTH = loopback_pkg::TAG_MID_WIDTH + loopback_pkg::CORE_WIDTH_DEF,
    parameter int USER_WIDTH = loopback_pkg::PORT_WIDTH,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire [DATA_WIDTH-1:0]   s_axis_tdata,
    input  wire [KEEP_WIDTH-1:0]   s_axis_tkeep,
    input  wire                    s_axis_tvalid,
    input  wire                    s_axis_tlast,
    input  wire [DEST_WIDTH-1:0]   s_axis_tdest,
    input  wire [USER_WIDTH-1:0]   s_axis_tuser,
    output logic                   s_axis_tready,

    output logic [DATA_WIDTH-1:0]  m_axis_tdata,
    output logic [KEEP_WIDTH-1:0]  m_axis_tkeep,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast,
    output logic [DEST_WIDTH-1:0]  m_axis_tdest,
    output logic [USER_WIDTH-1:0]  m_axis_tuser,
    input  wire                    m_axis_tready
);

    import loopback_pkg::*;

    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int PTR_WIDTH  = ADDR_WIDTH + 1; // extra wrap bit.
    localparam int WORD_WIDTH = DATA_WIDTH + KEEP_WIDTH + 1 + DEST_WIDTH + USER_WIDTH;

    logic [WORD_WIDTH-1:0] mem [DEPTH];
    logic [WORD_WIDTH-1:0] wr_word;
    logic [WORD_WIDTH-1:0] out_word;
    logic                  out_valid;

    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [PTR_WIDTH-1:0]  mem_count;
    logic [PTR_WIDTH-1:0]  stored;
    logic                  empty;
    logic                  push;
    logic                  load_out;

    // ******************************
    // occupancy.
    // ******************************
    assign mem_count = wr_ptr - rd_ptr;
    assign empty     = (wr_ptr == rd_ptr);

    // output register counts toward the depth.
    assign stored        = mem_count + {{ADDR_WIDTH{1'b0}}, out_valid};
    assign s_axis_tready = (stored != PTR_WIDTH'(DEPTH));

    assign push     = s_axis_tvalid && s_axis_tready;
    assign load_out = !empty && (!out_valid || m_axis_tready); // refill on empty or take.

    // ******************************
    // write side.
    // ******************************
    assign wr_word = {s_axis_tdata, s_axis_tkeep, s_axis_tlast, s_axis_tdest, s_axis_tuser};

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ******************************
    // read side.
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (load_out) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_out) begin
            out_valid <= 1'b1;
        end else if (m_axis_tready) begin
            out_valid <= 1'b0; // beat taken, nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    assign m_axis_tvalid = out_valid;
    assign {m_axis_tdata, m_axis_tkeep, m_axis_tlast, m_axis_tdest, m_axis_tuser} = out_word;

endmodule

`default_nettype wire

// ==== loopback/loopback_dest_lut.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopback_dest_lut #(
    parameter int CORE_WIDTH = loopback_pkg::CORE_WIDTH_DEF,
    parameter int SLOT_WIDTH = loopback_pkg::SLOT_WIDTH_DEF,
    parameter int PORT_COUNT = loopback_pkg::PORT_COUNT_DEF,
    localparam int TAG_WIDTH   = loopback_pkg::TAG_MID_WIDTH + CORE_WIDTH,
    localparam int INDEX_WIDTH = CORE_WIDTH + SLOT_WIDTH
) (
    input  wire                               clk,
    input  wire                               rst_n,

    input  wire [TAG_WIDTH-1:0]               msg_src,
    input  wire [TAG_WIDTH-1:0]               msg_dest,
    input  wire                               msg_valid,
    output logic                              msg_ready,

    input  wire [PORT_COUNT*INDEX_WIDTH-1:0]  lut_index,
    output logic [PORT_COUNT*TAG_WIDTH-1:0]   lut_tag,
    output logic [PORT_COUNT-1:0]             lut_hit
);

    import loopback_pkg::*;

    localparam int ENTRIES = 2 ** INDEX_WIDTH;

    logic [TAG_WIDTH-1:0]      tag_mem [ENTRIES];
    logic [ENTRIES-1:0]        entry_valid;
    logic [TAG_CALC_WIDTH-1:0] wr_index_full;
    logic [INDEX_WIDTH-1:0]    wr_index;

    assign msg_ready = 1'b1; // one write per cycle, never stalls.

    assign wr_index_full = tag_to_index(TAG_CALC_WIDTH'(msg_src), CORE_WIDTH, SLOT_WIDTH);
    assign wr_index      = wr_index_full[INDEX_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (msg_valid) begin
            tag_mem[wr_index] <= msg_dest;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (msg_valid) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

    // ******************************
    // lookup, one per lane.
    // ******************************
    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_read
        logic [INDEX_WIDTH-1:0] rd_index;
        assign rd_index                          = lut_index[p*INDEX_WIDTH +: INDEX_WIDTH];
        assign lut_tag[p*TAG_WIDTH +: TAG_WIDTH] = tag_mem[rd_index];
        assign lut_hit[p]                        = entry_valid[rd_index];
    end

endmodule

`default_nettype wire

// ==== loopback/loopback_msg_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopback_msg_fifo #(
    parameter int DATA_WIDTH = loopback_pkg::DATA_WIDTH_DEF,
    parameter int PORT_COUNT = loopback_pkg::PORT_COUNT_DEF,
    parameter int CORE_WIDTH = loopback_pkg::CORE_WIDTH_DEF,
    parameter int SLOT_WIDTH = loopback_pkg::SLOT_WIDTH_DEF,
    parameter int FIFO_DEPTH = loopback_pkg::FIFO_DEPTH_DEF,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8,
    localparam int TAG_WIDTH  = loopback_pkg::TAG_MID_WIDTH + CORE_WIDTH
) (
    input  wire                                          clk,
    input  wire                                          rst_n,

    input  wire [PORT_COUNT*DATA_WIDTH-1:0]              s_axis_tdata,
    input  wire [PORT_COUNT*KEEP_WIDTH-1:0]              s_axis_tkeep,
    input  wire [PORT_COUNT-1:0]                         s_axis_tvalid,
    input  wire [PORT_COUNT-1:0]                         s_axis_tlast,
    input  wire [PORT_COUNT*loopback_pkg::PORT_WIDTH-1:0] s_axis_tdest,
    input  wire [PORT_COUNT*TAG_WIDTH-1:0]               s_axis_tuser,
    output logic [PORT_COUNT-1:0]                        s_axis_tready,

    output logic [PORT_COUNT*DATA_WIDTH-1:0]             m_axis_tdata,
    output logic [PORT_COUNT*KEEP_WIDTH-1:0]             m_axis_tkeep,
    output logic [PORT_COUNT-1:0]                        m_axis_tvalid,
    output logic [PORT_COUNT-1:0]                        m_axis_tlast,
    output logic [PORT_COUNT*TAG_WIDTH-1:0]              m_axis_tdest,
    output logic [PORT_COUNT*loopback_pkg::PORT_WIDTH-1:0] m_axis_tuser,
    input  wire [PORT_COUNT-1:0]                         m_axis_tready,

    input  wire [TAG_WIDTH-1:0]                          msg_src,
    input  wire [TAG_WIDTH-1:0]                          msg_dest,
    input  wire                                          msg_valid,
    output logic                                         msg_ready
);

    import loopback_pkg::*;

    localparam int INDEX_WIDTH = CORE_WIDTH + SLOT_WIDTH;

    logic [PORT_COUNT*INDEX_WIDTH-1:0] lut_index;
    logic [PORT_COUNT*TAG_WIDTH-1:0]   lut_tag;
    logic [PORT_COUNT-1:0]             lut_hit;

    loopback_dest_lut #(
        .CORE_WIDTH (CORE_WIDTH),
        .SLOT_WIDTH (SLOT_WIDTH),
        .PORT_COUNT (PORT_COUNT)
    ) i_dest_lut (
        .clk        (clk),
        .rst_n      (rst_n),
        .msg_src    (msg_src),
        .msg_dest   (msg_dest),
        .msg_valid  (msg_valid),
        .msg_ready  (msg_ready),
        .lut_index  (lut_index),
        .lut_tag    (lut_tag),
        .lut_hit    (lut_hit)
    );

    // ******************************
    // lanes.
    // ******************************
    for (genvar i = 0; i < PORT_COUNT; i++) begin : g_lane
        logic [TAG_WIDTH-1:0]      src_tag;
        logic [TAG_CALC_WIDTH-1:0] index_full;
        logic [TAG_WIDTH-1:0]      res_tag;

        assign src_tag    = s_axis_tuser[i*TAG_WIDTH +: TAG_WIDTH];
        assign index_full = tag_to_index(TAG_CALC_WIDTH'(src_tag), CORE_WIDTH, SLOT_WIDTH);
        assign lut_index[i*INDEX_WIDTH +: INDEX_WIDTH] = index_full[INDEX_WIDTH-1:0];

        // unmapped entry loops back to the sender.
        assign res_tag = lut_hit[i] ? lut_tag[i*TAG_WIDTH +: TAG_WIDTH] : src_tag;

        axis_fifo #(
            .DATA_WIDTH (DATA_WIDTH),
            .DEPTH      (FIFO_DEPTH),
            .DEST_WIDTH (TAG_WIDTH),
            .USER_WIDTH (PORT_WIDTH)
        ) i_fifo (
            .clk           (clk),
            .rst_n         (rst_n),
            .s_axis_tdata  (s_axis_tdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .s_axis_tkeep  (s_axis_tkeep[i*KEEP_WIDTH +: KEEP_WIDTH]),
            .s_axis_tvalid (s_axis_tvalid[i]),
            .s_axis_tlast  (s_axis_tlast[i]),
            .s_axis_tdest  (res_tag),                                   // tag goes out on dest.
            .s_axis_tuser  (s_axis_tdest[i*PORT_WIDTH +: PORT_WIDTH]),  // port number on user.
            .s_axis_tready (s_axis_tready[i]),
            .m_axis_tdata  (m_axis_tdata[i*DATA_WIDTH +: DATA_WIDTH]),
            .m_axis_tkeep  (m_axis_tkeep[i*KEEP_WIDTH +: KEEP_WIDTH]),
            .m_axis_tvalid (m_axis_tvalid[i]),
            .m_axis_tlast  (m_axis_tlast[i]),
            .m_axis_tdest  (m_axis_tdest[i*TAG_WIDTH +: TAG_WIDTH]),
            .m_axis_tuser  (m_axis_tuser[i*PORT_WIDTH +: PORT_WIDTH]),
            .m_axis_tready (m_axis_tready[i])
        );
    end

endmodule

`default_nettype wire

// ==== loopback/loopback_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopback_top #(
    parameter int DATA_WIDTH = loopback_pkg::DATA_WIDTH_DEF,
    parameter int PORT_COUNT = loopback_pkg::PORT_COUNT_DEF,
    parameter int CORE_WIDTH = loopback_pkg::CORE_WIDTH_DEF,
    parameter int SLOT_WIDTH = loopback_pkg::SLOT_WIDTH_DEF,
    parameter int FIFO_DEPTH = loopback_pkg::FIFO_DEPTH_DEF,
    localparam int KEEP_WIDTH = DATA_WIDTH / 8,
    localparam int TAG_WIDTH  = loopback_pkg::TAG_MID_WIDTH + CORE_WIDTH
) (
    input  wire                                          clk,
    input  wire                                          rst_n,

    // ******************************
    // from the cores.
    // ******************************
    input  wire [PORT_COUNT*DATA_WIDTH-1:0]              s_axis_tdata,
    input  wire [PORT_COUNT*KEEP_WIDTH-1:0]              s_axis_tkeep,
    input  wire [PORT_COUNT-1:0]                         s_axis_tvalid,
    input  wire [PORT_COUNT-1:0]                         s_axis_tlast,
    input  wire [PORT_COUNT*loopback_pkg::PORT_WIDTH-1:0] s_axis_tdest,
    input  wire [PORT_COUNT*TAG_WIDTH-1:0]               s_axis_tuser,
    output logic [PORT_COUNT-1:0]                        s_axis_tready,

    // ******************************
    // back toward the cores.
    // ******************************
    output logic [PORT_COUNT*DATA_WIDTH-1:0]             m_axis_tdata,
    output logic [PORT_COUNT*KEEP_WIDTH-1:0]             m_axis_tkeep,
    output logic [PORT_COUNT-1:0]                        m_axis_tvalid,
    output logic [PORT_COUNT-1:0]                        m_axis_tlast,
    output logic [PORT_COUNT*TAG_WIDTH-1:0]              m_axis_tdest,
    output logic [PORT_COUNT*loopback_pkg::PORT_WIDTH-1:0] m_axis_tuser,
    input  wire [PORT_COUNT-1:0]                         m_axis_tready,

    // map writes.
    input  wire [TAG_WIDTH-1:0]                          msg_src,
    input  wire [TAG_WIDTH-1:0]                          msg_dest,
    input  wire                                          msg_valid,
    output logic                                         msg_ready
);

    import loopback_pkg::*;

    loopback_msg_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .PORT_COUNT (PORT_COUNT),
        .CORE_WIDTH (CORE_WIDTH),
        .SLOT_WIDTH (SLOT_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_msg_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tdest  (s_axis_tdest),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready),
        .msg_src       (msg_src),
        .msg_dest      (msg_dest),
        .msg_valid     (msg_valid),
        .msg_ready     (msg_ready)
    );

endmodule

`default_nettype wire

// ==== tests/tb_loopback_table.svh ====
`ifndef TB_LOOPBACK_TABLE_SVH
`define TB_LOOPBACK_TABLE_SVH

// each row holds kind, lane, port, src tag, tag, count, last keep and full mask.
// a write maps src to tag. a frame sends count beats and tag is the expected tdest.
// a stall holds m_axis_tready low for count cycles. a drain waits for all lanes
// to go idle, and full mask holds the lanes whose s_axis_tready must have dropped.

localparam logic [1:0] ROW_WRITE = 2'd0;
localparam logic [1:0] ROW_FRAME = 2'd1;
localparam logic [1:0] ROW_STALL = 2'd2;
localparam logic [1:0] ROW_DRAIN = 2'd3;

typedef struct packed {
    logic [1:0]            kind;
    logic                  lane;
    logic [PORT_WIDTH-1:0] port;
    logic [TW-1:0]         src;
    logic [TW-1:0]         tag;
    logic [7:0]            count;
    logic [KW-1:0]         last_keep;
    logic [LANES-1:0]      full_mask;
} row_t;

localparam int NUM_ROWS = 20;

localparam row_t ROWS [NUM_ROWS] = '{
    '{ROW_FRAME, 1'b0, 2'd1, 9'h0a5, 9'h0a5, 8'd4,  8'h0f, 2'b00}, // no map yet.
    '{ROW_FRAME, 1'b1, 2'd2, 9'h1c3, 9'h1c3, 8'd3,  8'hff, 2'b00},
    '{ROW_DRAIN, 1'b0, 2'd0, 9'h000, 9'h000, 8'd0,  8'h00, 2'b00},
    '{ROW_WRITE, 1'b0, 2'd0, 9'h0a5, 9'h123, 8'd0,  8'h00, 2'b00},
    '{ROW_FRAME, 1'b0, 2'd3, 9'h0a5, 9'h123, 8'd2,  8'hff, 2'b00},
    '{ROW_FRAME, 1'b1, 2'd0, 9'h0bd, 9'h123, 8'd2,  8'h03, 2'b00}, // middle bits differ.
    '{ROW_DRAIN, 1'b0, 2'd0, 9'h000, 9'h000, 8'd0,  8'h00, 2'b00},
    '{ROW_WRITE, 1'b0, 2'd0, 9'h0a5, 9'h044, 8'd0,  8'h00, 2'b00}, // overwrite.
    '{ROW_WRITE, 1'b0, 2'd0, 9'h1c3, 9'h0f0, 8'd0,  8'h00, 2'b00},
    '{ROW_FRAME, 1'b0, 2'd1, 9'h0a5, 9'h044, 8'd5,  8'hff, 2'b00},
    '{ROW_FRAME, 1'b1, 2'd2, 9'h1c3, 9'h0f0, 8'd5,  8'h07, 2'b00},
    '{ROW_DRAIN, 1'b0, 2'd0, 9'h000, 9'h000, 8'd0,  8'h00, 2'b00},
    '{ROW_STALL, 1'b0, 2'd0, 9'h000, 9'h000, 8'd40, 8'h00, 2'b00},
    '{ROW_FRAME, 1'b0, 2'd2, 9'h062, 9'h062, 8'd24, 8'h3f, 2'b00},
    '{ROW_FRAME, 1'b1, 2'd1, 9'h1c3, 9'h0f0, 8'd20, 8'hff, 2'b00},
    '{ROW_DRAIN, 1'b0, 2'd0, 9'h000, 9'h000, 8'd0,  8'h00, 2'b01},
    '{ROW_FRAME, 1'b0, 2'd0, 9'h1ff, 9'h1ff, 8'd1,  8'h01, 2'b00}, // single beats.
    '{ROW_FRAME, 1'b0, 2'd1, 9'h0a5, 9'h044, 8'd1,  8'hff, 2'b00},
    '{ROW_FRAME, 1'b1, 2'd3, 9'h0bd, 9'h044, 8'd3,  8'h1f, 2'b00},
    '{ROW_DRAIN, 1'b0, 2'd0, 9'h000, 9'h000, 8'd0,  8'h00, 2'b00}
};

`endif

// ==== tests/tb_loopback.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_loopback;

    import loopback_pkg::*;

    localparam int DW    = 64;
    localparam int KW    = DW / 8;
    localparam int LANES = 2;
    localparam int CW    = 4;
    localparam int SW    = 3;
    localparam int TW    = TAG_MID_WIDTH + CW;
    localparam int IW    = CW + SW;

    `include "tb_loopback_table.svh"

    typedef struct packed {
        logic [DW-1:0]         data;
        logic [KW-1:0]         keep;
        logic                  last;
        logic [TW-1:0]         tag;  // src tag when sent, resolved tag when expected.
        logic [PORT_WIDTH-1:0] port;
        logic [7:0]            row;
    } beat_t;

    logic                        clk;
    logic                        rst_n;
    logic [LANES*DW-1:0]         s_axis_tdata;
    logic [LANES*KW-1:0]         s_axis_tkeep;
    logic [LANES-1:0]            s_axis_tvalid;
    logic [LANES-1:0]            s_axis_tlast;
    logic [LANES*PORT_WIDTH-1:0] s_axis_tdest;
    logic [LANES*TW-1:0]         s_axis_tuser;
    logic [LANES-1:0]            s_axis_tready;
    logic [LANES*DW-1:0]         m_axis_tdata;
    logic [LANES*KW-1:0]         m_axis_tkeep;
    logic [LANES-1:0]            m_axis_tvalid;
    logic [LANES-1:0]            m_axis_tlast;
    logic [LANES*TW-1:0]         m_axis_tdest;
    logic [LANES*PORT_WIDTH-1:0] m_axis_tuser;
    logic [LANES-1:0]            m_axis_tready;
    logic [TW-1:0]               msg_src;
    logic [TW-1:0]               msg_dest;
    logic                        msg_valid;
    logic                        msg_ready;

    beat_t            send_q [LANES][$];
    beat_t            exp_q [LANES][$];
    logic [LANES-1:0] took;
    logic [LANES-1:0] full_seen;
    int               stall_left [LANES];
    logic [TW-1:0]    model_tag [2**IW];
    logic             model_valid [2**IW];
    int               row_err [NUM_ROWS];
    int               errors;
    int               limit;
    int               cycles;

    loopback_top #(
        .DATA_WIDTH (DW),
        .PORT_COUNT (LANES),
        .CORE_WIDTH (CW),
        .SLOT_WIDTH (SW),
        .FIFO_DEPTH (16)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tdest  (s_axis_tdest),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdest  (m_axis_tdest),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready),
        .msg_src       (msg_src),
        .msg_dest      (msg_dest),
        .msg_valid     (msg_valid),
        .msg_ready     (msg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // model and checks.
    // ******************************
    function automatic int map_index(input logic [TW-1:0] tag);
        logic [TAG_CALC_WIDTH-1:0] full;
        full = tag_to_index(TAG_CALC_WIDTH'(tag), CW, SW);
        return int'(full[IW-1:0]);
    endfunction

    task automatic flag_mismatch(input int row, input int l, input string field,
                                 input logic [DW-1:0] got, input logic [DW-1:0] exp);
        $display("ERROR %0t: row %0d lane %0d %s got %h expected %h",
                 $time, row, l, field, got, exp);
        errors++;
        row_err[row]++;
    endtask

    task automatic check_beat(input int l);
        beat_t e;
        assert (exp_q[l].size() != 0) else begin
            $display("ERROR %0t: lane %0d sent a beat with none expected", $time, l);
            errors++;
        end
        if (exp_q[l].size() != 0) begin
            e = exp_q[l].pop_front();
            assert (m_axis_tdata[l*DW +: DW] == e.data)
                else flag_mismatch(int'(e.row), l, "tdata", m_axis_tdata[l*DW +: DW], e.data);
            assert (m_axis_tkeep[l*KW +: KW] == e.keep)
                else flag_mismatch(int'(e.row), l, "tkeep",
                                   DW'(m_axis_tkeep[l*KW +: KW]), DW'(e.keep));
            assert (m_axis_tlast[l] == e.last)
                else flag_mismatch(int'(e.row), l, "tlast", DW'(m_axis_tlast[l]), DW'(e.last));
            assert (m_axis_tdest[l*TW +: TW] == e.tag)
                else flag_mismatch(int'(e.row), l, "tdest",
                                   DW'(m_axis_tdest[l*TW +: TW]), DW'(e.tag));
            assert (m_axis_tuser[l*PORT_WIDTH +: PORT_WIDTH] == e.port)
                else flag_mismatch(int'(e.row), l, "tuser",
                                   DW'(m_axis_tuser[l*PORT_WIDTH +: PORT_WIDTH]), DW'(e.port));
            if (e.last) begin
                $display("row %0d frame on lane %0d: %s", e.row, l,
                         row_err[e.row] == 0 ? "pass" : "fail");
            end
        end
    endtask

    // ******************************
    // one clock of stimulus.
    // ******************************
    task automatic cycle();
        beat_t b;
        for (int l = 0; l < LANES; l++) begin
            if (took[l]) begin
                b = send_q[l].pop_front();
            end
            s_axis_tvalid[l] = (send_q[l].size() != 0);
            if (s_axis_tvalid[l]) begin
                b = send_q[l][0];
                s_axis_tdata[l*DW +: DW]                 = b.data;
                s_axis_tkeep[l*KW +: KW]                 = b.keep;
                s_axis_tlast[l]                          = b.last;
                s_axis_tdest[l*PORT_WIDTH +: PORT_WIDTH] = b.port;
                s_axis_tuser[l*TW +: TW]                 = b.tag;
            end
            took[l] = s_axis_tvalid[l] && s_axis_tready[l]; // tready holds until the edge.
            if (!s_axis_tready[l]) begin
                full_seen[l] = 1'b1;
            end
            m_axis_tready[l] = (stall_left[l] == 0);
            if (stall_left[l] > 0) begin
                stall_left[l]--;
            end
            if (m_axis_tvalid[l] && m_axis_tready[l]) begin
                check_beat(l);
            end
        end
        @(negedge clk);
    endtask

    task automatic push_frame(input int row, input row_t r);
        beat_t         b;
        int            n;
        int            idx;
        logic [TW-1:0] res;
        n   = int'(r.count);
        idx = map_index(r.src);
        res = model_valid[idx] ? model_tag[idx] : r.src; // unmapped goes back to sender.
        assert (res == r.tag) else begin
            $display("ERROR %0t: row %0d model tag %h differs from table %h",
                     $time, row, res, r.tag);
            errors++;
            row_err[row]++;
        end
        for (int k = 0; k < n; k++) begin
            b.data = {$urandom, $urandom};
            b.last = (k == n - 1);
            b.keep = b.last ? r.last_keep : {KW{1'b1}};
            b.port = r.port;
            b.row  = 8'(row);
            b.tag  = r.src;
            send_q[r.lane].push_back(b);
            b.tag  = res;
            exp_q[r.lane].push_back(b);
        end
    endtask

    function automatic int pending();
        int total;
        total = 0;
        for (int l = 0; l < LANES; l++) begin
            total += send_q[l].size() + exp_q[l].size();
        end
        return total;
    endfunction

    task automatic drain(input int row, input logic [LANES-1:0] mask);
        while (pending() != 0) begin
            cycle();
        end
        assert (full_seen == mask) else begin
            $display("ERROR %0t: row %0d tready dropped on lanes %b, expected %b",
                     $time, row, full_seen, mask);
            errors++;
            row_err[row]++;
        end
        full_seen = '0;
        $display("row %0d drain: %s", row, row_err[row] == 0 ? "pass" : "fail");
    endtask

    initial begin
        int          idx;
        int          passed;
        row_t        r;
        rst_n         = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        s_axis_tdest  = '0;
        s_axis_tuser  = '0;
        m_axis_tready = '1;
        msg_src       = '0;
        msg_dest      = '0;
        msg_valid     = 1'b0;
        took          = '0;
        full_seen     = '0;
        errors        = 0;
        void'($urandom(32'he7cfff77));
        for (int l = 0; l < LANES; l++) begin
            stall_left[l] = 0;
        end
        for (int i = 0; i < 2**IW; i++) begin
            model_valid[i] = 1'b0;
        end
        limit = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_err[i] = 0;
            if (ROWS[i].kind == ROW_FRAME) begin
                limit += 4 * int'(ROWS[i].count);
            end else if (ROWS[i].kind == ROW_STALL) begin
                limit += int'(ROWS[i].count);
            end
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (m_axis_tvalid == '0 && s_axis_tready == '1) else begin
            $display("ERROR %0t: stream outputs not idle after reset", $time);
            errors++;
        end
        $display("reset state: %s", errors == 0 ? "pass" : "fail");

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = ROWS[i];
            case (r.kind)
                ROW_WRITE: begin
                    idx              = map_index(r.src);
                    model_tag[idx]   = r.tag;
                    model_valid[idx] = 1'b1;
                    msg_src          = r.src;
                    msg_dest         = r.tag;
                    msg_valid        = 1'b1;
                    assert (msg_ready == 1'b1) else begin
                        $display("ERROR %0t: row %0d msg_ready low during a map write",
                                 $time, i);
                        errors++;
                        row_err[i]++;
                    end
                    cycle();
                    msg_valid        = 1'b0;
                    $display("row %0d map write %h to %h: %s", i, r.src, r.tag,
                             row_err[i] == 0 ? "pass" : "fail");
                end
                ROW_FRAME: push_frame(i, r);
                ROW_STALL: begin
                    stall_left[r.lane] = int'(r.count);
                    $display("row %0d stall lane %0d for %0d cycles: pass", i, r.lane, r.count);
                end
                default: drain(i, r.full_mask);
            endcase
        end

        passed = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_err[i] == 0) begin
                passed++;
            end
        end
        $display("rows: %0d passed, %0d failed, %0d errors", passed, NUM_ROWS - passed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        cycles = 0;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
common/loopback_pkg.sv
logic/axis_fifo.sv
loopback/loopback_dest_lut.sv
loopback/loopback_msg_fifo.sv
loopback/loopback_top.sv
tests/tb_loopback.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_loopback \
    -o tb_loopback

out=$(./obj_dir/tb_loopback)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "Result: PASSED"
